//--- test/sonar_stim.mem
// Columns: opcode address data expected, all hex
// Opcodes 0 test end, 1 write, 2 read, 3 PDM, 4 clear, 5 wait, 6 irq, 7 mic clock, F stop
2 30000004 00000000 00000031
2 30000000 00000000 00000000
6 00000000 00000000 00000000
2 3000000C 00000000 00000000
2 3000004C 00000000 00000000
2 3000008C 00000000 00000000
2 300000CC 00000000 00000000
0 00000001 00000000 00000000
1 30000004 FFFFFFFF 00000000
2 30000004 00000000 000003FF
1 30000004 00000003 00000000
1 30000008 00008005 00000000
2 30000008 00000000 FFFF8005
1 30000048 00001234 00000000
2 30000008 00000000 FFFF8005
2 30000048 00000000 00001234
2 20000004 00000000 00000000
1 40000004 000000AA 00000000
2 30000004 00000000 00000003
2 30000108 00000000 00000000
0 00000002 00000000 00000000
3 00000000 00000001 00000000
5 00000000 00000100 00000000
5 00000000 00000030 00000000
2 3000000C 00000000 00000004
2 3000004C 00000000 FFFFFFFC
0 00000003 00000000 00000000
1 30000048 00008000 00000000
1 30000008 00000003 00000000
1 30000010 00000001 00000000
2 30000000 00000000 00000001
6 00000000 00000000 00000001
1 30000008 00000004 00000000
5 00000000 00000014 00000000
2 30000000 00000000 00000000
6 00000000 00000000 00000000
0 00000004 00000000 00000000
1 30000008 00000003 00000000
3 00000000 0000000F 00000000
4 00000000 00000001 00000000
5 00000000 00000020 00000000
2 3000000C 00000000 00000000
2 3000004C 00000000 00000000
2 3000008C 00000000 00000000
2 300000CC 00000000 00000000
2 30000000 00000000 00000000
6 00000000 00000000 00000000
4 00000000 00000000 00000000
0 00000005 00000000 00000000
7 00000000 000000A0 00000028
0 00000006 00000000 00000000
F 00000000 00000000 00000000

//--- files.f
logic/sonar_map_pkg.sv
logic/sonar_dsp_pkg.sv
logic/chan_bus_if.sv
logic/sonar_clk_gen.sv
logic/sonar_channel.sv
logic/sonar_host_regs.sv
logic/sonar_array_top.sv
test/tb_sonar_array.sv

//--- Makefile
TOP = tb_sonar_array

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- test/tb_sonar_array.sv
/* Testbench for the sonar array top level
   Replays the operations of test/sonar_stim.mem against the DUT and prints one line per test */
module tb_sonar_array;

  localparam int NUM_CHANNELS = 4;
  localparam int MCLK_DIV     = 4;
  localparam int RESET_CYCLES = 16;
  localparam int STIM_WORDS   = 512;
  localparam int ACK_LIMIT    = 4;

  // Opcodes of the stimulus file
  localparam logic [31:0] OP_TEST_END = 32'h0;
  localparam logic [31:0] OP_WRITE    = 32'h1;
  localparam logic [31:0] OP_READ     = 32'h2;
  localparam logic [31:0] OP_PDM      = 32'h3;
  localparam logic [31:0] OP_CLEAR    = 32'h4;
  localparam logic [31:0] OP_WAIT     = 32'h5;
  localparam logic [31:0] OP_IRQ      = 32'h6;
  localparam logic [31:0] OP_MIC      = 32'h7;
  localparam logic [31:0] OP_STOP     = 32'hF;

  logic                    wb_clk_i;
  logic                    wb_rst_i;
  logic                    wbs_cyc_i;
  logic                    wbs_stb_i;
  logic                    wbs_we_i;
  logic [3:0]              wbs_sel_i;
  logic [31:0]             wbs_adr_i;
  logic [31:0]             wbs_dat_i;
  logic                    wbs_ack_o;
  logic [31:0]             wbs_dat_o;
  logic [NUM_CHANNELS-1:0] pdm_data_i;
  logic                    pdm_clear_i;
  logic                    mic_clk_o;
  logic                    irq_o;

  logic [31:0] stim [0:STIM_WORDS-1];
  int          cycle_cnt    = 0;
  int          cycle_limit  = 1_000_000;
  int          test_errors  = 0;
  int          total_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  sonar_array_top #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .MCLK_DIV     (MCLK_DIV)
  ) DUT (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_dat_o   (wbs_dat_o),
    .pdm_data_i  (pdm_data_i),
    .pdm_clear_i (pdm_clear_i),
    .mic_clk_o   (mic_clk_o),
    .irq_o       (irq_o)
  );

  initial wb_clk_i = 1'b0;
  always #5 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // Twice the waits plus 10 cycles per bus access, on top of reset
  function automatic int cycle_budget();
    int waits;
    int accesses;
    waits = 0;
    accesses = 0;
    for (int i = 0; i + 3 < STIM_WORDS; i += 4) begin
      if (stim[i] == OP_STOP) break;
      if (stim[i] == OP_WAIT || stim[i] == OP_MIC) waits += int'(stim[i+2]);
      if (stim[i] == OP_WRITE || stim[i] == OP_READ) accesses++;
    end
    return 2 * waits + 10 * accesses + RESET_CYCLES;
  endfunction

  // Single Wishbone classic cycle, strobe dropped on the cycle after the acknowledge
  task automatic wb_access(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic got_ack;
    got_ack = 1'b0;
    rdata = '0;
    @(posedge wb_clk_i);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= write;
    wbs_sel_i <= 4'hF;
    wbs_adr_i <= addr;
    wbs_dat_i <= wdata;
    for (int n = 0; n < ACK_LIMIT && !got_ack; n++) begin
      @(negedge wb_clk_i);
      if (wbs_ack_o) begin
        got_ack = 1'b1;
        rdata = wbs_dat_o;
      end
    end
    assert (got_ack) else begin
      $display("No acknowledge within %0d cycles for address %h", ACK_LIMIT, addr);
      test_errors++;
    end
    @(posedge wb_clk_i);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
    wbs_sel_i <= 4'h0;
  endtask

  // Counts rising edges and measures every complete high phase
  task automatic check_mic_clock(input int cycles, input int exp_rises);
    int   rises;
    int   high_run;
    logic prev;
    logic seen_rise;
    rises = 0;
    high_run = 0;
    seen_rise = 1'b0;
    @(negedge wb_clk_i);
    prev = mic_clk_o;
    repeat (cycles) begin
      @(negedge wb_clk_i);
      if (!prev && mic_clk_o) begin
        rises++;
        seen_rise = 1'b1;
        high_run = 1;
      end else if (prev && mic_clk_o) begin
        high_run++;
      end else if (prev && !mic_clk_o && seen_rise) begin
        assert (high_run == MCLK_DIV / 2) else begin
          $display("CHECK FAILED mic_clk_o high cycles: expected %h, got %h",
                   MCLK_DIV / 2, high_run);
          test_errors++;
        end
      end
      prev = mic_clk_o;
    end
    assert (rises == exp_rises) else begin
      $display("CHECK FAILED mic_clk_o rising edges: expected %h, got %h", exp_rises, rises);
      test_errors++;
    end
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] rdata;
    int          idx;
    logic        done;
    wb_rst_i    = 1'b1;
    wbs_cyc_i   = 1'b0;
    wbs_stb_i   = 1'b0;
    wbs_we_i    = 1'b0;
    wbs_sel_i   = 4'h0;
    wbs_adr_i   = '0;
    wbs_dat_i   = '0;
    pdm_data_i  = '0;
    pdm_clear_i = 1'b0;
    $readmemh("test/sonar_stim.mem", stim);
    cycle_limit = cycle_budget();
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    idx = 0;
    done = 1'b0;
    while (!done && idx + 3 < STIM_WORDS) begin
      op       = stim[idx];
      addr     = stim[idx+1];
      data     = stim[idx+2];
      expected = stim[idx+3];
      idx += 4;
      case (op)
        OP_WRITE: wb_access(1'b1, addr, data, rdata);
        OP_READ: begin
          wb_access(1'b0, addr, '0, rdata);
          assert (rdata === expected) else begin
            $display("CHECK FAILED wbs_dat_o at %h: expected %h, got %h", addr, expected, rdata);
            test_errors++;
          end
        end
        OP_PDM: begin
          @(posedge wb_clk_i);
          pdm_data_i <= data[NUM_CHANNELS-1:0];
        end
        OP_CLEAR: begin
          @(posedge wb_clk_i);
          pdm_clear_i <= data[0];
        end
        OP_WAIT: repeat (int'(data)) @(posedge wb_clk_i);
        OP_IRQ: begin
          @(negedge wb_clk_i);
          assert (irq_o === expected[0]) else begin
            $display("CHECK FAILED irq_o: expected %h, got %h", expected[0], irq_o);
            test_errors++;
          end
        end
        OP_MIC: check_mic_clock(int'(data), int'(expected));
        OP_TEST_END: begin
          if (test_errors == 0) begin
            $display("Test %0d: PASS", addr);
            tests_passed++;
          end else begin
            $display("Test %0d: FAIL with %0d errors", addr, test_errors);
            tests_failed++;
          end
          total_errors += test_errors;
          test_errors = 0;
        end
        OP_STOP: done = 1'b1;
        default: begin
          $display("Unknown opcode %h in stimulus operation %0d", op, idx / 4);
          test_errors++;
          done = 1'b1;
        end
      endcase
    end
    total_errors += test_errors;
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- logic/sonar_array_top.sv
/* Top level of the sonar listening array
   Wishbone slave with NUM_CHANNELS PDM inputs, a microphone clock output and an interrupt */
module sonar_array_top #(
  parameter int NUM_CHANNELS = 4,
  parameter int MCLK_DIV     = 4
) (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wbs_cyc_i,
  input  logic                               wbs_stb_i,
  input  logic                               wbs_we_i,
  input  logic [3:0]                         wbs_sel_i,
  input  logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_adr_i,
  input  logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_dat_i,
  output logic                               wbs_ack_o,
  output logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_dat_o,
  input  logic [NUM_CHANNELS-1:0]            pdm_data_i,
  input  logic                               pdm_clear_i,
  output logic                               mic_clk_o,
  output logic                               irq_o
);
  import sonar_dsp_pkg::*;

  prescale_t prescale;
  logic      ce_pdm;
  logic      ce_pcm;

  chan_bus_if #(.NUM_CHANNELS(NUM_CHANNELS)) chan_bus ();

  sonar_clk_gen #(
    .MCLK_DIV (MCLK_DIV)
  ) u_clk_gen (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .prescale_i (prescale),
    .mic_clk_o  (mic_clk_o),
    .ce_pdm_o   (ce_pdm),
    .ce_pcm_o   (ce_pcm)
  );

  sonar_host_regs #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_host_regs (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbs_cyc_i  (wbs_cyc_i),
    .wbs_stb_i  (wbs_stb_i),
    .wbs_we_i   (wbs_we_i),
    .wbs_sel_i  (wbs_sel_i),
    .wbs_adr_i  (wbs_adr_i),
    .wbs_dat_i  (wbs_dat_i),
    .wbs_ack_o  (wbs_ack_o),
    .wbs_dat_o  (wbs_dat_o),
    .bus        (chan_bus.host),
    .prescale_o (prescale),
    .irq_o      (irq_o)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    sonar_channel #(
      .CHAN_INDEX (i)
    ) u_channel (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .bus         (chan_bus.chan),
      .ce_pdm_i    (ce_pdm),
      .ce_pcm_i    (ce_pcm),
      .pdm_data_i  (pdm_data_i[i]),
      .pdm_clear_i (pdm_clear_i)
    );
  end

endmodule

//--- logic/sonar_host_regs.sv
/* Wishbone slave front end of the sonar array
   Decodes accesses into the host registers or one channel bank, muxes the reply back
   and keeps the detect status and the interrupt */
module sonar_host_regs #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wbs_cyc_i,
  input  logic                               wbs_stb_i,
  input  logic                               wbs_we_i,
  input  logic [3:0]                         wbs_sel_i,
  input  logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_adr_i,
  input  logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_dat_i,
  output logic                               wbs_ack_o,
  output logic [sonar_map_pkg::WB_WIDTH-1:0] wbs_dat_o,
  chan_bus_if.host                           bus,
  output sonar_dsp_pkg::prescale_t           prescale_o,
  output logic                               irq_o
);
  import sonar_map_pkg::*;
  import sonar_dsp_pkg::*;

  localparam int WIDX_W     = 10;
  localparam int CHAN_NUM_W = WIDX_W - CHAN_REGS_LOG2;

  logic                    start;
  logic                    region_hit;
  logic                    wr_qual;
  logic [WIDX_W-1:0]       word_idx;
  logic [WIDX_W-1:0]       chan_off;
  logic [CHAN_NUM_W-1:0]   chan_num;
  logic                    chan_access;
  logic [NUM_CHANNELS-1:0] sel_vec;
  logic [REG_WIDTH-1:0]    chan_rdata;
  logic                    chan_ack;
  logic                    host_ack_q;
  logic [WB_WIDTH-1:0]     host_rdata_q;
  logic [NUM_CHANNELS-1:0] status_q;

  // Only the first cycle of an access counts, the acknowledge cycle is ignored
  assign start      = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
  assign region_hit = (wbs_adr_i[WB_WIDTH-1:WB_WIDTH-4] == HOST_REGION);
  assign wr_qual    = wbs_we_i && (wbs_sel_i != 4'b0000);
  assign word_idx   = wbs_adr_i[WIDX_W+1:2];

  assign chan_off    = word_idx - WIDX_W'(CHAN_BASE_IDX);
  assign chan_num    = chan_off[WIDX_W-1:CHAN_REGS_LOG2];
  assign chan_access = start && region_hit && (word_idx >= WIDX_W'(CHAN_BASE_IDX)) &&
                       (int'(chan_num) < NUM_CHANNELS);

  always_comb begin
    sel_vec = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (chan_access && int'(chan_num) == i) begin
        sel_vec[i] = 1'b1;
      end
    end
  end

  assign bus.sel     = sel_vec;
  assign bus.reg_idx = chan_off[CHAN_REGS_LOG2-1:0];
  assign bus.wdata   = wbs_dat_i[REG_WIDTH-1:0];
  assign bus.we      = wr_qual;

  // Host registers and unmapped accesses are answered here
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      host_ack_q <= 1'b0;
      prescale_o <= prescale_t'(PRESCALE_RESET);
    end else begin
      host_ack_q <= start && !chan_access;
      if (start && region_hit && wr_qual && word_idx == WIDX_W'(PRESCALE_IDX)) begin
        prescale_o <= wbs_dat_i[PRESCALE_BITS-1:0];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (start && !chan_access) begin
      if (region_hit && word_idx == WIDX_W'(STATUS_IDX)) begin
        host_rdata_q <= WB_WIDTH'(status_q);
      end else if (region_hit && word_idx == WIDX_W'(PRESCALE_IDX)) begin
        host_rdata_q <= WB_WIDTH'(prescale_o);
      end else begin
        host_rdata_q <= '0;
      end
    end
  end

  // At most one channel acknowledges at a time
  always_comb begin
    chan_rdata = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (bus.ack[i]) begin
        chan_rdata = chan_rdata | bus.rdata[i];
      end
    end
  end

  assign chan_ack  = |bus.ack;
  assign wbs_ack_o = host_ack_q || chan_ack;
  assign wbs_dat_o = chan_ack ?
                     {{(WB_WIDTH-REG_WIDTH){chan_rdata[REG_WIDTH-1]}}, chan_rdata} :
                     host_rdata_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      status_q <= '0;
    end else begin
      status_q <= bus.detect;
    end
  end

  assign irq_o = |status_q;

endmodule

//--- logic/sonar_channel.sv
/* One sonar listening channel
   Decimates its PDM stream into PCM samples, compares them against a threshold
   and serves its threshold, sample and control registers on the channel bus */
module sonar_channel #(
  parameter int CHAN_INDEX = 0
) (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  chan_bus_if.chan bus,
  input  logic     ce_pdm_i,
  input  logic     ce_pcm_i,
  input  logic     pdm_data_i,
  input  logic     pdm_clear_i
);
  import sonar_map_pkg::*;
  import sonar_dsp_pkg::*;

  logic                 sel;
  logic                 wr_en;
  threshold_t           thresh_q;
  logic                 enable_q;
  pcm_sample_t          pcm_q;
  pcm_sample_t          acc_q;
  pcm_sample_t          acc_nxt;
  logic                 detect_q;
  logic                 ack_q;
  logic [REG_WIDTH-1:0] rdata_q;

  assign sel   = bus.sel[CHAN_INDEX];
  assign wr_en = sel && bus.we;

  // Register bank
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      thresh_q <= '0;
      enable_q <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= sel;
      if (wr_en && bus.reg_idx == CHAN_THRESH) begin
        thresh_q <= threshold_t'(bus.wdata);
      end
      if (wr_en && bus.reg_idx == CHAN_CTRL) begin
        enable_q <= bus.wdata[0];
      end
    end
  end

  // Read data is captured with the select and shown with the acknowledge
  always_ff @(posedge wb_clk_i) begin
    if (sel) begin
      case (bus.reg_idx)
        CHAN_THRESH: rdata_q <= thresh_q;
        CHAN_PCM:    rdata_q <= pcm_q;
        CHAN_CTRL:   rdata_q <= {{(REG_WIDTH-1){1'b0}}, enable_q};
        default:     rdata_q <= '0;
      endcase
    end
  end

  // Each PDM bit counts as +1 or -1
  assign acc_nxt = pdm_data_i ? acc_q + 16'sd1 : acc_q - 16'sd1;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || pdm_clear_i) begin
      acc_q <= '0;
      pcm_q <= '0;
    end else if (ce_pdm_i) begin
      if (ce_pcm_i) begin
        // Window end takes this cycle's bit too
        pcm_q <= acc_nxt;
        acc_q <= '0;
      end else begin
        acc_q <= acc_nxt;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      detect_q <= 1'b0;
    end else begin
      detect_q <= enable_q && (pcm_q > thresh_q);
    end
  end

  assign bus.ack[CHAN_INDEX]    = ack_q;
  assign bus.rdata[CHAN_INDEX]  = rdata_q;
  assign bus.detect[CHAN_INDEX] = detect_q;

endmodule

//--- logic/sonar_clk_gen.sv
/* Clock generator for the microphones and the decimators
   Produces the microphone clock, a PDM sample enable and a PCM window enable */
module sonar_clk_gen #(
  parameter int MCLK_DIV = 4
) (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  sonar_dsp_pkg::prescale_t prescale_i,
  output logic                     mic_clk_o,
  output logic                     ce_pdm_o,
  output logic                     ce_pcm_o
);
  import sonar_dsp_pkg::*;

  localparam int DIV_W = $clog2(MCLK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(MCLK_DIV - 1);
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(MCLK_DIV / 2);

  logic [DIV_W-1:0] div_cnt;
  logic [DIV_W-1:0] div_nxt;
  logic             pdm_tick;
  prescale_t        win_cnt;

  assign pdm_tick = (div_cnt == DIV_LAST);
  assign div_nxt  = pdm_tick ? '0 : div_cnt + 1'b1;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      // Start on the last phase so the first period is a full one
      div_cnt   <= DIV_LAST;
      mic_clk_o <= 1'b0;
      ce_pdm_o  <= 1'b0;
      ce_pcm_o  <= 1'b0;
      win_cnt   <= prescale_i;
    end else begin
      div_cnt   <= div_nxt;
      mic_clk_o <= (div_nxt < DIV_HALF);
      ce_pdm_o  <= pdm_tick;
      ce_pcm_o  <= pdm_tick && (win_cnt == '0);
      if (pdm_tick) begin
        // New prescale value is picked up only at a window boundary
        if (win_cnt == '0) begin
          win_cnt <= prescale_i;
        end else begin
          win_cnt <= win_cnt - 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/chan_bus_if.sv
/* Register bus between the host decoder and the channel array
   The host drives one select bit per access, channels answer on their own slice */
interface chan_bus_if #(
  parameter int NUM_CHANNELS = 4
);
  import sonar_map_pkg::*;

  logic [NUM_CHANNELS-1:0]                sel;
  chan_reg_t                              reg_idx;
  logic [REG_WIDTH-1:0]                   wdata;
  logic                                   we;

  logic [NUM_CHANNELS-1:0]                ack;
  logic [NUM_CHANNELS-1:0][REG_WIDTH-1:0] rdata;
  logic [NUM_CHANNELS-1:0]                detect;

  modport host (
    output sel, reg_idx, wdata, we,
    input  ack, rdata, detect
  );

  modport chan (
    input  sel, reg_idx, wdata, we,
    output ack, rdata, detect
  );

endinterface

//--- logic/sonar_dsp_pkg.sv
/* Data types of the decimation and detection path
   Used by the channels for samples and thresholds and by the clock generator for the window */
package sonar_dsp_pkg;

  // Decimated PDM sample, signed two's complement
  typedef logic signed [15:0] pcm_sample_t;

  // Detect threshold, compared signed against the sample
  typedef logic signed [15:0] threshold_t;

  // Window length minus one, counted in PDM clock enables
  typedef logic [sonar_map_pkg::PRESCALE_BITS-1:0] prescale_t;

endpackage

//--- logic/sonar_map_pkg.sv
/* Register map of the sonar array
   Bus widths, word indices and reset values shared by the host decoder and the channels */
package sonar_map_pkg;

  // Wishbone data and address width
  localparam int WB_WIDTH = 32;

  // Width of every channel register
  localparam int REG_WIDTH = 16;

  // Address bits 31..28 select this block
  localparam logic [3:0] HOST_REGION = 4'd3;

  // Host word indices
  localparam int STATUS_IDX   = 0;
  localparam int PRESCALE_IDX = 1;

  // Channel banks start here, 16 words each
  localparam int CHAN_BASE_IDX  = 2;
  localparam int CHAN_REGS_LOG2 = 4;

  typedef logic [CHAN_REGS_LOG2-1:0] chan_reg_t;

  // Registers inside one channel bank
  localparam chan_reg_t CHAN_THRESH = 4'd0;
  localparam chan_reg_t CHAN_PCM    = 4'd1;
  localparam chan_reg_t CHAN_CTRL   = 4'd2;

  // Prescaler holds the decimation window length minus one
  localparam int PRESCALE_BITS  = 10;
  localparam int PRESCALE_RESET = 49;

endpackage
